// File: hdl/adapter_cfg_pkg.sv
/*
  Sizing constants of the loopback adapter:
    host and fabric stream widths, lane count of the width converters,
    depth and pointer width of the stream FIFOs
*/

package adapter_cfg_pkg;

  // ------------------------------------------------------------------
  // stream widths
  // ------------------------------------------------------------------
  localparam int WIDE_W     = 128;                 // host side word
  localparam int NARROW_W   = 32;                  // fabric side beat
  localparam int LANES      = WIDE_W / NARROW_W;   // narrow beats per word
  localparam int LANE_IDX_W = $clog2(LANES);       // lane counter width

  // ------------------------------------------------------------------
  // buffering
  // ------------------------------------------------------------------
  // depth is kept a power of two so the pointers wrap on their own
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);  // read/write pointer width

endpackage

// File: hdl/beat_pkg.sv
/*
  Wide stream word type.
    wide_word_t packed union
      flat : whole host word, used by the slice and the FIFOs
      lane : narrow lanes, lane 0 in the low bits, used by the
             width converters
*/

package beat_pkg;

  // ------------------------------------------------------------------
  // one host word, seen flat or split into fabric lanes
  // ------------------------------------------------------------------
  typedef union packed {
    logic [adapter_cfg_pkg::WIDE_W-1:0]  flat;    // host view
    logic [adapter_cfg_pkg::LANES-1:0]
          [adapter_cfg_pkg::NARROW_W-1:0] lane;   // lane 0 sent first
  } wide_word_t;

endpackage

// File: hdl/stream_if.sv
/*
  Valid/ready stream bundle with last-beat marking.
    source modport drives tvalid, tdata, tlast
    sink modport drives tready
*/

`timescale 1ns/1ps

interface stream_if #(
  parameter int DATA_W = 32
);

  logic              tvalid;   // beat offered
  logic              tready;   // beat taken
  logic [DATA_W-1:0] tdata;
  logic              tlast;    // final beat of a packet

  modport source (
    output tvalid,
    output tdata,
    output tlast,
    input  tready
  );

  modport sink (
    input  tvalid,
    input  tdata,
    input  tlast,
    output tready
  );

endinterface

// File: hdl/host_reg_slice.sv
/*
  Host input register slice.
    main output register plus one skid entry, so the input tready
    comes straight from a flop and not from the downstream tready
*/

`timescale 1ns/1ps

module host_reg_slice (
  input  logic     clk_i,
  input  logic     rst_i,
  stream_if.sink   in_s,
  stream_if.source out_m
);

  logic                               main_valid_q;
  logic [adapter_cfg_pkg::WIDE_W-1:0] main_data_q;
  logic                               main_last_q;
  logic                               skid_valid_q;
  logic [adapter_cfg_pkg::WIDE_W-1:0] skid_data_q;
  logic                               skid_last_q;

  logic in_fire;
  logic main_load;   // main register free this cycle

  assign in_fire   = in_s.tvalid & in_s.tready;
  assign main_load = ~main_valid_q | out_m.tready;

  assign in_s.tready  = ~skid_valid_q;   // flop output only
  assign out_m.tvalid = main_valid_q;
  assign out_m.tdata  = main_data_q;
  assign out_m.tlast  = main_last_q;

  // ------------------------------------------------------------------
  // occupancy
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_load) begin
      main_valid_q <= skid_valid_q | in_fire;
      skid_valid_q <= 1'b0;            // skid drains into main
    end else if (in_fire) begin
      skid_valid_q <= 1'b1;            // output stalled, park the beat
    end
  end

  // ------------------------------------------------------------------
  // payload
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (main_load) begin
      main_data_q <= skid_valid_q ? skid_data_q : in_s.tdata;
      main_last_q <= skid_valid_q ? skid_last_q : in_s.tlast;
    end else if (in_fire) begin
      skid_data_q <= in_s.tdata;
      skid_last_q <= in_s.tlast;
    end
  end

endmodule

// File: hdl/beat_fifo.sv
/*
  Synchronous first-word-fall-through FIFO of host words.
    circular store of FIFO_DEPTH words with their last flags
    read and write pointers, occupancy count
    head entry shown directly on the read stream
*/

`timescale 1ns/1ps

module beat_fifo (
  input  logic     clk_i,
  input  logic     rst_i,
  stream_if.sink   wr_s,
  stream_if.source rd_m
);

  beat_pkg::wide_word_t                   mem_data [adapter_cfg_pkg::FIFO_DEPTH];
  logic [adapter_cfg_pkg::FIFO_DEPTH-1:0] mem_last;

  logic [adapter_cfg_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
  logic [adapter_cfg_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
  logic [adapter_cfg_pkg::FIFO_PTR_W:0]   count_q;   // one bit wider, holds a full count

  logic empty;
  logic full;
  logic wr_fire;
  logic rd_fire;

  assign empty = (count_q == '0);
  assign full  = (count_q == (adapter_cfg_pkg::FIFO_PTR_W + 1)'(adapter_cfg_pkg::FIFO_DEPTH));

  assign wr_fire = wr_s.tvalid & wr_s.tready;
  assign rd_fire = rd_m.tvalid & rd_m.tready;

  assign wr_s.tready = ~full;
  assign rd_m.tvalid = ~empty;
  assign rd_m.tdata  = mem_data[rd_ptr_q].flat;   // fall-through head
  assign rd_m.tlast  = mem_last[rd_ptr_q];

  // ------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      mem_data[wr_ptr_q].flat <= wr_s.tdata;
      mem_last[wr_ptr_q]      <= wr_s.tlast;
    end
  end

  // ------------------------------------------------------------------
  // pointers and count
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at depth
      end
      if (rd_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_fire, rd_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // none or both
      endcase
    end
  end

endmodule

// File: hdl/width_down.sv
/*
  Wide to narrow width converter.
    latches one host word, sends its lanes lane 0 first
    last flag goes out on the final lane only
*/

`timescale 1ns/1ps

module width_down (
  input  logic     clk_i,
  input  logic     rst_i,
  stream_if.sink   wide_s,
  stream_if.source narrow_m
);

  beat_pkg::wide_word_t                   word_q;
  logic                                   last_q;
  logic                                   full_q;   // word held
  logic [adapter_cfg_pkg::LANE_IDX_W-1:0] lane_q;

  logic wide_fire;
  logic narrow_fire;
  logic final_lane;

  assign final_lane  = (lane_q == adapter_cfg_pkg::LANE_IDX_W'(adapter_cfg_pkg::LANES - 1));
  assign wide_fire   = wide_s.tvalid & wide_s.tready;
  assign narrow_fire = narrow_m.tvalid & narrow_m.tready;

  // refill in the cycle the final lane leaves
  assign wide_s.tready = ~full_q | (narrow_fire & final_lane);

  assign narrow_m.tvalid = full_q;
  assign narrow_m.tdata  = word_q.lane[lane_q];
  assign narrow_m.tlast  = last_q & final_lane;

  // ------------------------------------------------------------------
  // lane stepping
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
      lane_q <= '0;
    end else begin
      if (wide_fire) begin
        full_q <= 1'b1;
      end else if (narrow_fire && final_lane) begin
        full_q <= 1'b0;                // word fully sent
      end
      if (narrow_fire) begin
        lane_q <= final_lane ? '0 : lane_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wide_fire) begin
      word_q.flat <= wide_s.tdata;
      last_q      <= wide_s.tlast;
    end
  end

endmodule

// File: hdl/width_up.sv
/*
  Narrow to wide width converter.
    writes each fabric beat into its lane of a host word
    presents the word after the final lane, with that beat's last flag,
    and blocks the narrow input until the word is taken
*/

`timescale 1ns/1ps

module width_up (
  input  logic     clk_i,
  input  logic     rst_i,
  stream_if.sink   narrow_s,
  stream_if.source wide_m
);

  beat_pkg::wide_word_t                   word_q;
  logic                                   last_q;
  logic                                   full_q;   // word complete, on output
  logic [adapter_cfg_pkg::LANE_IDX_W-1:0] lane_q;

  logic narrow_fire;
  logic wide_fire;
  logic final_lane;

  assign final_lane  = (lane_q == adapter_cfg_pkg::LANE_IDX_W'(adapter_cfg_pkg::LANES - 1));
  assign narrow_fire = narrow_s.tvalid & narrow_s.tready;
  assign wide_fire   = wide_m.tvalid & wide_m.tready;

  assign narrow_s.tready = ~full_q;   // stall while the word waits

  assign wide_m.tvalid = full_q;
  assign wide_m.tdata  = word_q.flat;
  assign wide_m.tlast  = last_q;

  // ------------------------------------------------------------------
  // lane gathering
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
      lane_q <= '0;
    end else if (narrow_fire) begin
      lane_q <= final_lane ? '0 : lane_q + 1'b1;
      full_q <= final_lane;
    end else if (wide_fire) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (narrow_fire) begin
      word_q.lane[lane_q] <= narrow_s.tdata;
      if (final_lane) begin
        last_q <= narrow_s.tlast;      // packet end rides the last lane
      end
    end
  end

endmodule

// File: hdl/adapter_top.sv
/*
  Loopback adapter top level.
    host input slice, transmit FIFO, downsizer,
    narrow loopback, upsizer, receive FIFO
    plain host ports mapped onto internal stream bundles
*/

`timescale 1ns/1ps

module adapter_top (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               s_valid_i,
  output logic                               s_ready_o,
  input  logic [adapter_cfg_pkg::WIDE_W-1:0] s_data_i,
  input  logic                               s_last_i,
  output logic                               m_valid_o,
  input  logic                               m_ready_i,
  output logic [adapter_cfg_pkg::WIDE_W-1:0] m_data_o,
  output logic                               m_last_o
);

  // ------------------------------------------------------------------
  // stream bundles, in chain order
  // ------------------------------------------------------------------
  stream_if #(.DATA_W(adapter_cfg_pkg::WIDE_W))   host_in    ();
  stream_if #(.DATA_W(adapter_cfg_pkg::WIDE_W))   host_q     ();
  stream_if #(.DATA_W(adapter_cfg_pkg::WIDE_W))   tx_wide    ();
  stream_if #(.DATA_W(adapter_cfg_pkg::NARROW_W)) fsb_narrow ();   // loopback
  stream_if #(.DATA_W(adapter_cfg_pkg::WIDE_W))   rx_wide    ();
  stream_if #(.DATA_W(adapter_cfg_pkg::WIDE_W))   host_out   ();

  // host ports
  assign host_in.tvalid = s_valid_i;
  assign host_in.tdata  = s_data_i;
  assign host_in.tlast  = s_last_i;
  assign s_ready_o      = host_in.tready;

  assign m_valid_o       = host_out.tvalid;
  assign m_data_o        = host_out.tdata;
  assign m_last_o        = host_out.tlast;
  assign host_out.tready = m_ready_i;

  // ------------------------------------------------------------------
  // transmit side
  // ------------------------------------------------------------------
  host_reg_slice u_host_slice (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .in_s  (host_in),
    .out_m (host_q)
  );

  beat_fifo tx_fifo (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .wr_s  (host_q),
    .rd_m  (tx_wide)
  );

  width_down u_width_down (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wide_s   (tx_wide),
    .narrow_m (fsb_narrow)   // straight into the upsizer
  );

  // ------------------------------------------------------------------
  // receive side
  // ------------------------------------------------------------------
  width_up u_width_up (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .narrow_s (fsb_narrow),
    .wide_m   (rx_wide)
  );

  beat_fifo rx_fifo (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .wr_s  (rx_wide),
    .rd_m  (host_out)
  );

endmodule

// File: tb/adapter_model.svh
/*
  Testbench scoreboard.
    queue of accepted host words with their last flags
    push on input transfer, pop on output transfer
    value compare with error report
*/

`ifndef ADAPTER_MODEL_SVH
`define ADAPTER_MODEL_SVH

typedef logic [adapter_cfg_pkg::WIDE_W-1:0] word_t;

word_t expected_data_q[$];   // oldest accepted word first
logic  expected_last_q[$];

task automatic push_expected(input word_t data, input logic last);
  expected_data_q.push_back(data);
  expected_last_q.push_back(last);
endtask

task automatic pop_expected(output word_t data, output logic last);
  if (expected_data_q.size() == 0) begin
    $display("an output word appeared with no accepted input word left to match it");
    $display("Done: errors found");
    $fatal(1);
  end else begin
    data = expected_data_q.pop_front();
    last = expected_last_q.pop_front();
  end
endtask

task automatic check_value(input string name, input word_t expected, input word_t actual);
  if (actual !== expected) begin
    $display("Error: %s expected %h actual %h", name, expected, actual);
    $display("Done: errors found");
    $fatal(1);
  end
endtask

`endif

// File: tb/adapter_tb.sv
/*
  Loopback adapter testbench.
    clock and reset, random host words with random gaps,
    random and held output back-pressure, scoreboard checks,
    watchdog, final report
*/

`timescale 1ns/1ps

module adapter_tb;

  `include "adapter_model.svh"

  localparam int CLK_PERIOD     = 4;
  localparam int SAMPLE_DELAY   = 1;     // after the falling edge, before the rising one
  localparam int RESET_CYCLES   = 5;
  localparam int WORD_COUNT     = 300;
  localparam int PHASE_A_CYCLES = 400;   // random output ready
  localparam int PHASE_B_CYCLES = 40;    // output held off
  localparam int STALL_BOUND    = 8 * adapter_cfg_pkg::LANES;   // worst cycles per word
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + PHASE_A_CYCLES + PHASE_B_CYCLES
                                  + WORD_COUNT * STALL_BOUND;

  logic  clk_i;
  logic  rst_i;
  logic  s_valid_i;
  logic  s_ready_o;
  word_t s_data_i;
  logic  s_last_i;
  logic  m_valid_o;
  logic  m_ready_i;
  word_t m_data_o;
  logic  m_last_o;

  int    in_count      = 0;
  int    out_count     = 0;
  int    words_sent    = 0;
  logic  in_taken      = 1'b0;   // offer taken at the coming rising edge
  logic  in_phase_b;
  logic  saw_ready_low = 1'b0;
  word_t exp_data;
  logic  exp_last;

  adapter_top uut (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s_valid_i (s_valid_i),
    .s_ready_o (s_ready_o),
    .s_data_i  (s_data_i),
    .s_last_i  (s_last_i),
    .m_valid_o (m_valid_o),
    .m_ready_i (m_ready_i),
    .m_data_o  (m_data_o),
    .m_last_o  (m_last_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("timeout: the adapter did not drain within %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $fatal(1);
  end

  function automatic word_t random_word();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // new offer only once the previous one is gone
  task automatic step_input(input logic allow_gap);
    if (!s_valid_i || in_taken) begin
      if (words_sent < WORD_COUNT && (!allow_gap || $urandom_range(3) != 0)) begin
        s_valid_i = 1'b1;
        s_data_i  = random_word();
        s_last_i  = ($urandom_range(3) == 0);   // one word in four ends a packet
        words_sent++;
      end else begin
        s_valid_i = 1'b0;
      end
    end
  endtask

  // ------------------------------------------------------------------
  // transfer monitor, samples between the edges
  // ------------------------------------------------------------------
  always begin
    @(negedge clk_i);
    #SAMPLE_DELAY;
    in_taken = 1'b0;
    if (!rst_i) begin
      if (s_valid_i && s_ready_o) begin
        in_taken = 1'b1;
        push_expected(s_data_i, s_last_i);
        in_count++;
      end
      if (m_valid_o && m_ready_i) begin
        pop_expected(exp_data, exp_last);
        check_value("data_integrity", exp_data, m_data_o);
        check_value("last_flag", word_t'(exp_last), word_t'(m_last_o));
        out_count++;
      end
      if (in_phase_b && m_valid_o && expected_data_q.size() != 0) begin
        // stalled output keeps showing the oldest word
        check_value("backpressure_head", expected_data_q[0], m_data_o);
        check_value("backpressure_last", word_t'(expected_last_q[0]), word_t'(m_last_o));
      end
      if (in_phase_b && !s_ready_o) begin
        saw_ready_low = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------
  initial begin
    void'($urandom(32'h3d4));
    rst_i      = 1'b1;
    s_valid_i  = 1'b0;
    s_data_i   = '0;
    s_last_i   = 1'b0;
    m_ready_i  = 1'b0;
    in_phase_b = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_i = 1'b0;

    @(negedge clk_i);
    #SAMPLE_DELAY;
    check_value("reset_m_valid", '0, word_t'(m_valid_o));
    check_value("reset_s_ready", word_t'(1), word_t'(s_ready_o));

    repeat (PHASE_A_CYCLES) begin   // random flow both ways
      @(negedge clk_i);
      step_input(1'b1);
      m_ready_i = ($urandom_range(1) == 1);
    end

    @(negedge clk_i);
    m_ready_i  = 1'b0;
    in_phase_b = 1'b1;
    step_input(1'b0);
    repeat (PHASE_B_CYCLES - 1) begin
      @(negedge clk_i);
      step_input(1'b0);       // back-to-back words fill every stage
    end

    @(negedge clk_i);
    in_phase_b = 1'b0;
    check_value("backpressure_hold", word_t'(1), word_t'(m_valid_o));
    check_value("backpressure_ready", word_t'(1), word_t'(saw_ready_low));
    m_ready_i = 1'b1;
    step_input(1'b1);
    while (words_sent < WORD_COUNT || s_valid_i || out_count < in_count) begin
      @(negedge clk_i);
      step_input(1'b1);
    end

    repeat (2 * adapter_cfg_pkg::LANES) @(negedge clk_i);   // catch stray extra words
    check_value("drain_m_valid", '0, word_t'(m_valid_o));
    check_value("drain_s_ready", word_t'(1), word_t'(s_ready_o));
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: build.f
+incdir+tb
hdl/adapter_cfg_pkg.sv
hdl/beat_pkg.sv
hdl/stream_if.sv
hdl/host_reg_slice.sv
hdl/beat_fifo.sv
hdl/width_down.sv
hdl/width_up.sv
hdl/adapter_top.sv
tb/adapter_tb.sv

// File: Makefile
# Verilator build and run of the loopback adapter testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make help   list the targets"
	@echo "  make test   build with Verilator and run the testbench"
	@echo "  make clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f build.f --top-module adapter_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vadapter_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
